/* verilog/sensor_pkg.sv */
// Sensor front end types
package sensor_pkg;

    // ==============================
    // Levels and debounce timing
    // ==============================
    typedef logic [7:0] level_t;

    localparam level_t level_full          = 8'd255;
    localparam level_t level_empty         = 8'd0;
    localparam level_t level_low_threshold = 8'd50;   // LED lights below this

    localparam int debounce_cycles_default = 1_000_000;   // 20 ms at 50 MHz
    localparam int debounce_cnt_w          = 20;          // Holds the default length

    // ==============================
    // Raw switch groups
    // ==============================
    typedef struct packed {
        logic fill;
        logic empty;
    } refill_sw_t;

    typedef struct packed {
        refill_sw_t bin0;
        refill_sw_t bin1;
        refill_sw_t creamer;
        refill_sw_t chocolate;
    } consumable_sw_t;

    typedef struct packed {
        logic paper_filter;
        logic pressure_ovr;   // Forces pressure not ok
        logic temp_ovr;       // Forces temperature not ready
        logic system_error;
    } status_sw_t;

    // ==============================
    // Sensor outputs
    // ==============================
    typedef struct packed {
        level_t bin0;
        level_t bin1;
        level_t creamer;
        level_t chocolate;
    } levels_t;

    typedef struct packed {
        logic paper_filter_present;
        logic water_pressure_ok;
        logic water_temp_ready;
        logic system_fault;
    } sensor_status_t;

    // Each LED lights on a warning, except the filter LED
    typedef struct packed {
        logic paper_filter;
        logic coffee_bin0;
        logic coffee_bin1;
        logic creamer;
        logic chocolate;
        logic water_pressure;
        logic water_temp;
        logic system_error;
    } led_t;

endpackage

/* verilog/switch_debouncer.sv */
// Counter based switch debouncer
module switch_debouncer #(
    parameter type payload_t       = logic,
    parameter int  debounce_cycles = sensor_pkg::debounce_cycles_default
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t raw,
    output payload_t clean
);
    import sensor_pkg::*;

    localparam int width = $bits(payload_t);

    // Count value seen on the Nth differing edge
    localparam logic [debounce_cnt_w-1:0] cnt_last = debounce_cnt_w'(debounce_cycles - 1);

    logic [width-1:0] raw_bits;
    logic [width-1:0] clean_bits;

    assign raw_bits = raw;
    assign clean    = payload_t'(clean_bits);

    // ==============================
    // One counter per switch bit
    // ==============================
    for (genvar i = 0; i < width; i++) begin : g_bit
        logic [debounce_cnt_w-1:0] cnt_q;
        logic                      clean_q;

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cnt_q   <= '0;
                clean_q <= 1'b0;
            end else if (raw_bits[i] == clean_q) begin
                cnt_q <= '0;                // Input agrees, start over
            end else if (cnt_q == cnt_last) begin
                cnt_q   <= '0;
                clean_q <= raw_bits[i];     // Stable long enough
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end

        assign clean_bits[i] = clean_q;

        // Counter is cleared on the Nth edge, so it never hits the length
        a_cnt_below_len: assert property (
            @(posedge clk) disable iff (!rst_n)
            int'(cnt_q) < debounce_cycles
        ) else $error("debounce counter %0d reached length %0d", cnt_q, debounce_cycles);
    end

endmodule

/* verilog/consumable_levels.sv */
// Consumable level registers
module consumable_levels (
    input  logic                       clk,
    input  logic                       rst_n,
    input  sensor_pkg::consumable_sw_t refill,   // Debounced fill and empty
    output sensor_pkg::levels_t        levels
);
    import sensor_pkg::*;

    // Fill beats empty, otherwise hold
    function automatic level_t next_level(refill_sw_t sw, level_t cur);
        if (sw.fill) begin
            return level_full;
        end else if (sw.empty) begin
            return level_empty;
        end
        return cur;
    endfunction

    function automatic logic is_full_or_empty(level_t lvl);
        return (lvl == level_full) || (lvl == level_empty);
    endfunction

    // ==============================
    // Level registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            levels.bin0      <= level_full;   // Machine starts stocked
            levels.bin1      <= level_full;
            levels.creamer   <= level_full;
            levels.chocolate <= level_full;
        end else begin
            levels.bin0      <= next_level(refill.bin0, levels.bin0);
            levels.bin1      <= next_level(refill.bin1, levels.bin1);
            levels.creamer   <= next_level(refill.creamer, levels.creamer);
            levels.chocolate <= next_level(refill.chocolate, levels.chocolate);
        end
    end

    // No depletion here, so only the two end values exist
    a_level_end_values: assert property (
        @(posedge clk) disable iff (!rst_n)
        is_full_or_empty(levels.bin0) && is_full_or_empty(levels.bin1) &&
        is_full_or_empty(levels.creamer) && is_full_or_empty(levels.chocolate)
    ) else $error("level outside full/empty: %h", levels);

endmodule

/* verilog/status_indicators.sv */
// Status registers and LED drivers
module status_indicators (
    input  logic                       clk,
    input  logic                       rst_n,
    input  sensor_pkg::status_sw_t     status_sw,   // Debounced status switches
    input  sensor_pkg::levels_t        levels,
    output sensor_pkg::sensor_status_t status,
    output sensor_pkg::led_t           leds
);
    import sensor_pkg::*;

    function automatic logic is_low(level_t lvl);
        return lvl < level_low_threshold;
    endfunction

    // ==============================
    // Status outputs
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status.paper_filter_present <= 1'b0;
            status.water_pressure_ok    <= 1'b1;   // Healthy until overridden
            status.water_temp_ready     <= 1'b1;
            status.system_fault         <= 1'b0;
        end else begin
            status.paper_filter_present <= status_sw.paper_filter;
            status.water_pressure_ok    <= ~status_sw.pressure_ovr;
            status.water_temp_ready     <= ~status_sw.temp_ovr;
            status.system_fault         <= status_sw.system_error;
        end
    end

    // ==============================
    // LED outputs
    // ==============================
    // One stage behind status and levels
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            leds <= '0;
        end else begin
            leds.paper_filter   <= status.paper_filter_present;
            leds.coffee_bin0    <= is_low(levels.bin0);
            leds.coffee_bin1    <= is_low(levels.bin1);
            leds.creamer        <= is_low(levels.creamer);
            leds.chocolate      <= is_low(levels.chocolate);
            leds.water_pressure <= ~status.water_pressure_ok;   // On when pressure bad
            leds.water_temp     <= ~status.water_temp_ready;
            leds.system_error   <= status.system_fault;
        end
    end

    // Pressure LED tracks the status one cycle later
    a_pressure_led_follows: assert property (
        @(posedge clk) disable iff (!rst_n)
        1'b1 |=> leds.water_pressure == !$past(status.water_pressure_ok)
    ) else $error("pressure LED %b does not follow status", leds.water_pressure);

endmodule

/* verilog/sensor_interface.sv */
// Coffee machine sensor front end
module sensor_interface #(
    parameter int debounce_cycles = sensor_pkg::debounce_cycles_default
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Raw board switches
    input  sensor_pkg::consumable_sw_t sw_consumable,
    input  sensor_pkg::status_sw_t     sw_status,

    // Sensor state toward the machine
    output sensor_pkg::levels_t        levels,
    output sensor_pkg::sensor_status_t status,
    output sensor_pkg::led_t           leds
);
    import sensor_pkg::*;

    consumable_sw_t consumable_db;   // Debounced fill/empty
    status_sw_t     status_db;       // Debounced status switches

    // ==============================
    // Switch debouncing
    // ==============================
    switch_debouncer #(
        .payload_t       (consumable_sw_t),
        .debounce_cycles (debounce_cycles)
    ) consumable_db_i (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (sw_consumable),
        .clean (consumable_db)
    );

    switch_debouncer #(
        .payload_t       (status_sw_t),
        .debounce_cycles (debounce_cycles)
    ) status_db_i (
        .clk   (clk),
        .rst_n (rst_n),
        .raw   (sw_status),
        .clean (status_db)
    );

    // ==============================
    // Levels, status and LEDs
    // ==============================
    consumable_levels levels_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .refill (consumable_db),
        .levels (levels)            // Also feeds the LED compare
    );

    status_indicators indicators_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .status_sw (status_db),
        .levels    (levels),
        .status    (status),
        .leds      (leds)
    );

endmodule

/* tests/tb_sensor_interface.sv */
// Sensor front end testbench
module tb_sensor_interface;
    import sensor_pkg::*;

    localparam int debounce_n    = 16;
    localparam int settle_cycles = debounce_n + 3;           // LEDs land at edge N+2
    localparam int max_cycles    = 40 * settle_cycles * 4;   // Near 3000 and twice the run

    localparam refill_sw_t sw_idle  = '{fill: 1'b0, empty: 1'b0};
    localparam refill_sw_t sw_fill  = '{fill: 1'b1, empty: 1'b0};
    localparam refill_sw_t sw_empty = '{fill: 1'b0, empty: 1'b1};
    localparam refill_sw_t sw_both  = '{fill: 1'b1, empty: 1'b1};

    logic           clk;
    logic           rst_n;
    consumable_sw_t sw_consumable;
    status_sw_t     sw_status;
    levels_t        levels;
    sensor_status_t status;
    led_t           leds;

    // Expected outputs, tracked from the raw switches
    levels_t        exp_levels;
    sensor_status_t exp_status;
    led_t           exp_leds;

    int level_errs = 0;
    int status_errs = 0;
    int led_errs = 0;
    int checks = 0;
    int cycle_cnt = 0;

    sensor_interface #(
        .debounce_cycles (debounce_n)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .sw_consumable (sw_consumable),
        .sw_status     (sw_status),
        .levels        (levels),
        .status        (status),
        .leds          (leds)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ==============================
    // Reference model
    // ==============================
    function automatic level_t level_model(refill_sw_t sw, level_t cur);
        return sw.fill ? level_full : (sw.empty ? level_empty : cur);   // Fill wins
    endfunction

    function automatic sensor_status_t status_model(status_sw_t sw);
        sensor_status_t st;
        st.paper_filter_present = sw.paper_filter;
        st.water_pressure_ok    = !sw.pressure_ovr;
        st.water_temp_ready     = !sw.temp_ovr;
        st.system_fault         = sw.system_error;
        return st;
    endfunction

    function automatic led_t led_model(sensor_status_t st, levels_t lv);
        led_t l;
        l.paper_filter   = st.paper_filter_present;
        l.coffee_bin0    = lv.bin0 < level_low_threshold;
        l.coffee_bin1    = lv.bin1 < level_low_threshold;
        l.creamer        = lv.creamer < level_low_threshold;
        l.chocolate      = lv.chocolate < level_low_threshold;
        l.water_pressure = !st.water_pressure_ok;
        l.water_temp     = !st.water_temp_ready;
        l.system_error   = st.system_fault;
        return l;
    endfunction

    // Switch pair for one consumable, others idle
    function automatic consumable_sw_t refill_for(int idx, refill_sw_t sw);
        consumable_sw_t c;
        c = '{bin0: sw_idle, bin1: sw_idle, creamer: sw_idle, chocolate: sw_idle};
        case (idx)
            0: c.bin0 = sw;
            1: c.bin1 = sw;
            2: c.creamer = sw;
            default: c.chocolate = sw;
        endcase
        return c;
    endfunction

    // ==============================
    // Compare tasks
    // ==============================
    task automatic check_levels(levels_t exp, string what);
        checks++;
        if (levels !== exp) begin
            level_errs++;
            $display("error: levels (%s) expected %h actual %h", what, exp, levels);
        end
    endtask

    task automatic check_status(sensor_status_t exp, string what);
        checks++;
        if (status !== exp) begin
            status_errs++;
            $display("error: status (%s) expected %h actual %h", what, exp, status);
        end
    endtask

    task automatic check_leds(led_t exp, string what);
        checks++;
        if (leds !== exp) begin
            led_errs++;
            $display("error: leds (%s) expected %h actual %h", what, exp, leds);
        end
    endtask

    task automatic drive(consumable_sw_t c, status_sw_t s);
        @(posedge clk);
        sw_consumable <= c;
        sw_status     <= s;
    endtask

    // Wait past the LED latency, then compare against the model
    task automatic settle_and_check(string what);
        repeat (settle_cycles) @(posedge clk);
        @(negedge clk);
        exp_levels.bin0      = level_model(sw_consumable.bin0, exp_levels.bin0);
        exp_levels.bin1      = level_model(sw_consumable.bin1, exp_levels.bin1);
        exp_levels.creamer   = level_model(sw_consumable.creamer, exp_levels.creamer);
        exp_levels.chocolate = level_model(sw_consumable.chocolate, exp_levels.chocolate);
        exp_status = status_model(sw_status);
        exp_leds   = led_model(exp_status, exp_levels);
        check_levels(exp_levels, what);
        check_status(exp_status, what);
        check_leds(exp_leds, what);
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic test_reset_values();
        @(negedge clk);
        exp_levels = '{bin0: level_full, bin1: level_full, creamer: level_full,
                       chocolate: level_full};
        exp_status = '{paper_filter_present: 1'b0, water_pressure_ok: 1'b1,
                       water_temp_ready: 1'b1, system_fault: 1'b0};
        exp_leds   = '0;
        check_levels(exp_levels, "reset");
        check_status(exp_status, "reset");
        check_leds(exp_leds, "reset");
    endtask

    task automatic test_empty_refill();
        for (int i = 0; i < 4; i++) begin
            drive(refill_for(i, sw_empty), '0);
            settle_and_check($sformatf("empty %0d", i));
            drive('0, '0);
            settle_and_check($sformatf("hold empty %0d", i));
            drive(refill_for(i, sw_fill), '0);
            settle_and_check($sformatf("fill %0d", i));
            drive('0, '0);
            settle_and_check($sformatf("hold full %0d", i));
        end
    endtask

    task automatic test_fill_priority();
        drive({4{sw_empty}}, '0);
        settle_and_check("all empty");
        drive({4{sw_both}}, '0);
        settle_and_check("fill and empty");
        drive('0, '0);
        settle_and_check("priority release");
    endtask

    task automatic test_status_lines();
        drive('0, '{paper_filter: 1'b1, pressure_ovr: 1'b1, temp_ovr: 1'b1,
                    system_error: 1'b1});
        settle_and_check("status set");
        drive('0, '0);
        settle_and_check("status release");
    endtask

    // Empty levels expose fill glitches and full levels expose empty glitches
    task automatic test_glitches();
        int          len;
        logic [11:0] flip;
        for (int pass = 0; pass < 2; pass++) begin
            drive(pass == 0 ? {4{sw_empty}} : {4{sw_fill}}, '0);
            settle_and_check($sformatf("glitch base %0d", pass));
            drive('0, '0);
            settle_and_check($sformatf("glitch base release %0d", pass));
            for (int b = 0; b < 12; b++) begin
                len  = $urandom_range(debounce_n - 1, 1);   // Always shorter than N
                flip = 12'b1 << b;
                @(posedge clk);
                {sw_consumable, sw_status} <= {sw_consumable, sw_status} ^ flip;
                repeat (len) @(posedge clk);
                {sw_consumable, sw_status} <= '0;
                settle_and_check($sformatf("glitch bit %0d len %0d", b, len));
            end
        end
    endtask

    task automatic test_exact_latency();
        levels_t new_levels;
        led_t    new_leds;
        int      k;
        new_levels      = exp_levels;
        new_levels.bin1 = level_empty;
        new_leds        = led_model(exp_status, new_levels);
        drive(refill_for(1, sw_empty), '0);
        for (k = 1; k <= debounce_n + 2; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_levels(k >= debounce_n + 1 ? new_levels : exp_levels,
                         $sformatf("latency edge %0d", k));
            check_leds(k >= debounce_n + 2 ? new_leds : exp_leds,
                       $sformatf("latency edge %0d", k));
        end
        exp_levels = new_levels;
        exp_leds   = new_leds;
        drive('0, '0);
        settle_and_check("latency release");
    endtask

    initial begin
        void'($urandom(32'hc54b));
        rst_n         = 1'b0;
        sw_consumable = '0;
        sw_status     = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_values();
        test_empty_refill();
        test_fill_priority();
        test_status_lines();
        test_glitches();
        test_exact_latency();

        $display("checks %0d, level errors %0d, status errors %0d, led errors %0d",
                 checks, level_errs, status_errs, led_errs);
        if (level_errs + status_errs + led_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
verilog/sensor_pkg.sv
verilog/switch_debouncer.sv
verilog/consumable_levels.sv
verilog/status_indicators.sv
verilog/sensor_interface.sv
tests/tb_sensor_interface.sv

/* Makefile */
# Verilator simulation of the sensor front end

TOP = tb_sensor_interface
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: PASS" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
